/* hw/exePkg.sv */
package exePkg;

	localparam int dataW = 32; // operand width
	localparam int shamtW = 5; // shift amount width
	localparam int prodW = 2 * dataW; // full product, hi and lo together

	// opcodes of the execute stage
	typedef enum logic [4:0] {
		opAdd   = 5'd0,
		opAddu  = 5'd1,
		opSub   = 5'd2,
		opSubu  = 5'd3,
		opOr    = 5'd4,
		opAnd   = 5'd5,
		opNor   = 5'd6,
		opXor   = 5'd7,
		opSll   = 5'd8,
		opSrl   = 5'd9,
		opSra   = 5'd10,
		opSlt   = 5'd11,
		opSltu  = 5'd12,
		opMult  = 5'd13, // hi/lo group starts here
		opMultu = 5'd14,
		opDiv   = 5'd15,
		opDivu  = 5'd16,
		opMfhi  = 5'd17,
		opMflo  = 5'd18,
		opMthi  = 5'd19,
		opMtlo  = 5'd20
	} exeOp;

endpackage

/* hw/intAlu.sv */
`timescale 1ns/1ns

module intAlu
	import exePkg::*;
(
	input exeOp op,
	input logic [dataW-1:0] a,
	input logic [dataW-1:0] b,
	input logic [shamtW-1:0] shamt,
	input logic shiftVar,
	output logic [dataW-1:0] aluResult,
	output logic aluOverflow
);

	logic [shamtW-1:0] shiftAmt;
	logic [dataW-1:0] sum;
	logic [dataW-1:0] diff;
	logic [dataW-1:0] sllResult;
	logic [dataW-1:0] srlResult;
	logic [dataW-1:0] sraResult;
	logic signed [dataW-1:0] bSigned;
	logic lessSigned;
	logic lessUnsigned;
	logic signA;
	logic signB;

	assign shiftAmt = shiftVar ? a[shamtW-1:0] : shamt; // variable shift uses low bits of a

	assign sum = a + b;
	assign diff = a - b;

	assign signA = a[dataW-1];
	assign signB = b[dataW-1];

	assign bSigned = b;
	assign sllResult = b << shiftAmt;
	assign srlResult = b >> shiftAmt;
	assign sraResult = bSigned >>> shiftAmt; // sign bit fills from the left

	assign lessUnsigned = a < b;
	// with mixed signs the negative operand is the smaller one
	assign lessSigned = (signA != signB) ? signA : lessUnsigned;

	always_comb begin
		case (op)
			opAdd,
			opAddu: aluResult = sum;
			opSub,
			opSubu: aluResult = diff;
			opOr: aluResult = a | b;
			opAnd: aluResult = a & b;
			opNor: aluResult = ~(a | b);
			opXor: aluResult = a ^ b;
			opSll: aluResult = sllResult;
			opSrl: aluResult = srlResult;
			opSra: aluResult = sraResult;
			opSlt: aluResult = {{(dataW-1){1'b0}}, lessSigned};
			opSltu: aluResult = {{(dataW-1){1'b0}}, lessUnsigned};
			default: aluResult = '0; // hi/lo group, not an alu op
		endcase
	end

	always_comb begin
		case (op)
			opAdd: begin
				// like signs in, other sign out
				aluOverflow = (signA == signB) && (sum[dataW-1] != signA);
			end
			opSub: begin
				aluOverflow = (signA != signB) && (diff[dataW-1] != signA);
			end
			default: aluOverflow = 1'b0; // unsigned forms never trap
		endcase
	end

endmodule

/* hw/mulDiv.sv */
`timescale 1ns/1ns

module mulDiv
	import exePkg::*;
(
	input exeOp op,
	input logic [dataW-1:0] a,
	input logic [dataW-1:0] b,
	output logic [dataW-1:0] hiNext,
	output logic [dataW-1:0] loNext,
	output logic divZero
);

	logic isDiv;
	logic bZero;
	logic [dataW-1:0] divisor;
	logic [prodW-1:0] prodU;
	logic [prodW-1:0] prodS;
	logic [dataW-1:0] quotU;
	logic [dataW-1:0] remU;
	logic [dataW-1:0] magA;
	logic [dataW-1:0] magB;
	logic [dataW-1:0] magQ;
	logic [dataW-1:0] magR;
	logic [dataW-1:0] quotS;
	logic [dataW-1:0] remS;
	logic negA;
	logic negB;

	assign isDiv = (op == opDiv) || (op == opDivu);
	assign bZero = (b == '0);
	assign divZero = isDiv && bZero;

	// keeps the dividers defined, result is dropped on divide by zero
	assign divisor = bZero ? {{(dataW-1){1'b0}}, 1'b1} : b;

	assign prodU = {{dataW{1'b0}}, a} * {{dataW{1'b0}}, b};
	assign prodS = {{dataW{a[dataW-1]}}, a} * {{dataW{b[dataW-1]}}, b}; // low 64 bits are exact

	assign quotU = a / divisor;
	assign remU = a % divisor;

	assign negA = a[dataW-1];
	assign negB = divisor[dataW-1];
	assign magA = negA ? (~a + 1'b1) : a;
	assign magB = negB ? (~divisor + 1'b1) : divisor;
	assign magQ = magA / magB;
	assign magR = magA % magB;

	// truncate toward zero, remainder follows the dividend
	assign quotS = (negA ^ negB) ? (~magQ + 1'b1) : magQ;
	assign remS = negA ? (~magR + 1'b1) : magR;

	always_comb begin
		case (op)
			opMult: {hiNext, loNext} = prodS;
			opMultu: {hiNext, loNext} = prodU;
			opDiv: begin
				hiNext = remS;
				loNext = quotS;
			end
			opDivu: begin
				hiNext = remU;
				loNext = quotU;
			end
			default: begin
				hiNext = '0;
				loNext = '0;
			end
		endcase
	end

endmodule

/* hw/hiLoResult.sv */
`timescale 1ns/1ns

module hiLoResult
	import exePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic issue,
	input exeOp op,
	input logic [dataW-1:0] a,
	input logic [dataW-1:0] aluResult,
	input logic [dataW-1:0] hiNext,
	input logic [dataW-1:0] loNext,
	input logic aluOverflow,
	input logic divZero,
	output logic resultValid,
	output logic [dataW-1:0] result,
	output logic overflow,
	output logic [dataW-1:0] hi,
	output logic [dataW-1:0] lo
);

	logic mulDivWe;
	logic hiWe;
	logic loWe;
	logic [dataW-1:0] hiD;
	logic [dataW-1:0] loD;
	logic [dataW-1:0] resultD;
	logic overflowD;

	always_comb begin
		case (op)
			opMult,
			opMultu: mulDivWe = 1'b1;
			opDiv,
			opDivu: mulDivWe = !divZero; // hi/lo kept on divide by zero
			default: mulDivWe = 1'b0;
		endcase
	end

	assign hiWe = issue && (mulDivWe || (op == opMthi));
	assign loWe = issue && (mulDivWe || (op == opMtlo));
	assign hiD = (op == opMthi) ? a : hiNext;
	assign loD = (op == opMtlo) ? a : loNext;

	// pick the value the stage hands on
	always_comb begin
		resultD = '0;
		overflowD = 1'b0;
		case (op)
			opMfhi: resultD = hi;
			opMflo: resultD = lo;
			opMult,
			opMultu,
			opDiv,
			opDivu,
			opMthi,
			opMtlo: resultD = '0; // strobe only, no data
			default: begin
				resultD = aluResult;
				overflowD = aluOverflow;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (hiWe)
				hi <= hiD;
			if (loWe)
				lo <= loD;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			result <= '0;
			overflow <= 1'b0;
		end else begin
			resultValid <= issue; // one cycle latency
			if (issue) begin
				result <= resultD;
				overflow <= overflowD;
			end
		end
	end

endmodule

/* hw/exeUnit.sv */
`timescale 1ns/1ns

module exeUnit
	import exePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic issue,
	input exeOp op,
	input logic [dataW-1:0] a,
	input logic [dataW-1:0] b,
	input logic [shamtW-1:0] shamt,
	input logic shiftVar,
	output logic resultValid,
	output logic [dataW-1:0] result,
	output logic overflow,
	output logic [dataW-1:0] hi,
	output logic [dataW-1:0] lo
);

	logic [dataW-1:0] aluResult;
	logic aluOverflow;
	logic [dataW-1:0] hiNext;
	logic [dataW-1:0] loNext;
	logic divZero;

	intAlu alu0 (
		.op(op),
		.a(a),
		.b(b),
		.shamt(shamt),
		.shiftVar(shiftVar),
		.aluResult(aluResult),
		.aluOverflow(aluOverflow)
	);

	mulDiv mulDiv0 (
		.op(op),
		.a(a),
		.b(b),
		.hiNext(hiNext),
		.loNext(loNext),
		.divZero(divZero)
	);

	hiLoResult hiLo0 (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.op(op),
		.a(a),
		.aluResult(aluResult),
		.hiNext(hiNext),
		.loNext(loNext),
		.aluOverflow(aluOverflow),
		.divZero(divZero),
		.resultValid(resultValid),
		.result(result),
		.overflow(overflow),
		.hi(hi),
		.lo(lo)
	);

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod = 10; // 20 ns clock
	localparam int resetCycles = 3;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2 rstN = 1'b1; // release off the edge
	end

endmodule

/* test/exeUnit_checker.sv */
`timescale 1ns/1ns

module exeUnitChecker
	import exePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic issue,
	input exeOp op,
	input logic resultValid,
	input logic [dataW-1:0] result,
	input logic overflow,
	input logic [dataW-1:0] hi,
	input logic [dataW-1:0] lo
);

	int assertFails = 0; // read by the testbench at the end

	strobeFollowsIssue: assert property (@(posedge clk) disable iff (!rstN)
		issue |=> resultValid)
	else begin
		assertFails++;
		$error("resultValid missing one cycle after issue");
	end

	noStrobeWithoutIssue: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |-> $past(issue))
	else begin
		assertFails++;
		$error("resultValid high without an issue in the previous cycle");
	end

	resetClearsOutputs: assert property (@(posedge clk)
		!rstN |-> (!resultValid && !overflow && result == '0 && hi == '0 && lo == '0))
	else begin
		assertFails++;
		$error("outputs not zero while reset is active");
	end

	unsignedNoOverflow: assert property (@(posedge clk) disable iff (!rstN)
		issue && (op inside {opAddu, opSubu, opSltu, opMultu, opDivu}) |=> !overflow)
	else begin
		assertFails++;
		$error("overflow set for an unsigned operation");
	end

endmodule

bind exeUnit exeUnitChecker checker0 (
	.clk(clk), .rstN(rstN), .issue(issue), .op(op),
	.resultValid(resultValid), .result(result), .overflow(overflow),
	.hi(hi), .lo(lo)
);

/* test/exeUnitTb.sv */
`timescale 1ns/1ns

module exeUnitTb
	import exePkg::*;
();

	localparam int clkPeriod = 20;
	localparam int sweepOps = 25 * (21 + 4 * 2); // mfhi and mflo after each mul/div
	localparam int randomCount = 200;
	localparam int plannedOps = sweepOps + randomCount + 4;
	localparam int spareCycles = 50; // reset, idle checks, drain
	localparam int timeLimit = (plannedOps + spareCycles) * clkPeriod;
	localparam longint intMax = 64'sd2147483647;
	localparam longint intMin = -64'sd2147483648;

	logic clk;
	logic rstN;
	logic issue;
	exeOp op;
	logic [dataW-1:0] a;
	logic [dataW-1:0] b;
	logic [shamtW-1:0] shamt;
	logic shiftVar;
	logic resultValid;
	logic [dataW-1:0] result;
	logic overflow;
	logic [dataW-1:0] hi;
	logic [dataW-1:0] lo;

	int seed = 32'hdf4f;
	int dataErrors = 0;
	int otherErrors = 0;
	logic [dataW-1:0] modelHi = '0;
	logic [dataW-1:0] modelLo = '0;
	logic [dataW-1:0] corners [5] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
	exeOp expOp [$];
	logic [dataW-1:0] expResult [$];
	logic expOverflow [$];
	logic [dataW-1:0] expHi [$];
	logic [dataW-1:0] expLo [$];

	clockGen clkGen0 (.clk(clk), .rstN(rstN));

	exeUnit dut0 (
		.clk(clk), .rstN(rstN), .issue(issue), .op(op), .a(a), .b(b),
		.shamt(shamt), .shiftVar(shiftVar), .resultValid(resultValid),
		.result(result), .overflow(overflow), .hi(hi), .lo(lo)
	);

	// own hi/lo copy, wide arithmetic for overflow and signed divide
	task automatic predict(input exeOp o, input logic [31:0] x, input logic [31:0] y,
			input logic [4:0] sa, input logic sv);
		longint sx;
		longint sy;
		logic [4:0] amt;
		logic [31:0] res;
		logic ovf;
		sx = longint'($signed(x));
		sy = longint'($signed(y));
		amt = sv ? x[4:0] : sa;
		res = '0;
		ovf = 1'b0;
		case (o)
			opAdd, opAddu: begin
				res = x + y;
				ovf = (o == opAdd) && (sx + sy > intMax || sx + sy < intMin);
			end
			opSub, opSubu: begin
				res = x - y;
				ovf = (o == opSub) && (sx - sy > intMax || sx - sy < intMin);
			end
			opOr: res = x | y;
			opAnd: res = x & y;
			opNor: res = ~(x | y);
			opXor: res = x ^ y;
			opSll: res = y << amt;
			opSrl: res = y >> amt;
			opSra: res = (y >> amt) | (y[31] ? ~(32'hffffffff >> amt) : 32'h0);
			opSlt: res = {31'b0, sx < sy};
			opSltu: res = {31'b0, x < y};
			opMult: {modelHi, modelLo} = sx * sy;
			opMultu: {modelHi, modelLo} = {32'b0, x} * {32'b0, y};
			opDiv: begin
				if (y != '0)
					{modelHi, modelLo} = {32'(sx % sy), 32'(sx / sy)};
			end
			opDivu: begin
				if (y != '0)
					{modelHi, modelLo} = {x % y, x / y};
			end
			opMfhi: res = modelHi;
			opMflo: res = modelLo;
			opMthi: modelHi = x;
			opMtlo: modelLo = x;
			default: res = '0;
		endcase
		expOp.push_back(o);
		expResult.push_back(res);
		expOverflow.push_back(ovf);
		expHi.push_back(modelHi);
		expLo.push_back(modelLo);
	endtask

	task automatic issueOp(input exeOp o, input logic [31:0] x, input logic [31:0] y,
			input logic [4:0] sa, input logic sv);
		@(posedge clk);
		#2;
		issue = 1'b1;
		op = o;
		a = x;
		b = y;
		shamt = sa;
		shiftVar = sv;
		predict(o, x, y, sa, sv);
	endtask

	task automatic idleCycle;
		@(posedge clk);
		#2;
		issue = 1'b0;
	endtask

	function automatic logic [31:0] pickOperand();
		logic [31:0] r;
		r = $random(seed);
		if (r[1:0] == 2'b00)
			r = corners[r[4:2] % 5]; // edge value now and then
		return r;
	endfunction

	task automatic cornerSweep;
		int i;
		int j;
		int k;
		exeOp o;
		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 5; j++) begin
				for (k = 0; k < 21; k++) begin
					o = exeOp'(5'(k));
					// shamt 0..31 by i, amount from a on odd j
					issueOp(o, corners[i], corners[j], 5'(i * 31 / 4), j[0]);
					if (o inside {opMult, opMultu, opDiv, opDivu}) begin
						issueOp(opMfhi, 32'h0, 32'h0, 5'd0, 1'b0);
						issueOp(opMflo, 32'h0, 32'h0, 5'd0, 1'b0);
					end
				end
			end
		end
	endtask

	task automatic randomTraffic;
		logic [31:0] r;
		repeat (randomCount) begin
			r = $random(seed);
			issueOp(exeOp'(5'(r[7:0] % 21)), pickOperand(), pickOperand(), r[12:8], r[13]);
		end
	endtask

	task automatic checkResult;
		exeOp o;
		logic [31:0] r;
		logic v;
		logic [31:0] h;
		logic [31:0] l;
		if (expOp.size() == 0) begin
			otherErrors++;
			$display("result strobe at %0t with no operation pending", $time);
		end else begin
			o = expOp.pop_front();
			r = expResult.pop_front();
			v = expOverflow.pop_front();
			h = expHi.pop_front();
			l = expLo.pop_front();
			assert (result === r && overflow === v) else begin
				dataErrors++;
				$display("FAIL %0t: %s result %h overflow %b, expected %h overflow %b",
					$time, o.name(), result, overflow, r, v);
			end
			assert (hi === h && lo === l) else begin
				dataErrors++;
				$display("FAIL %0t: %s hi %h lo %h, expected hi %h lo %h",
					$time, o.name(), hi, lo, h, l);
			end
		end
	endtask

	always @(negedge clk) begin
		if (resultValid === 1'b1)
			checkResult();
	end

	initial begin
		#(timeLimit);
		$display("timeout: run did not finish within %0d ns", timeLimit);
		$display("Test failed");
		$finish;
	end

	initial begin
		issue = 1'b0;
		op = opAdd;
		a = '0;
		b = '0;
		shamt = '0;
		shiftVar = 1'b0;
		repeat (6) begin // spans reset and the idle cycles after it
			@(negedge clk);
			assert (resultValid === 1'b0 && result === '0 && overflow === 1'b0 &&
					hi === '0 && lo === '0) else begin
				dataErrors++;
				$display("FAIL %0t: outputs not zero with no issue around reset", $time);
			end
		end
		cornerSweep();
		issueOp(opMthi, 32'h13579bdf, 32'h0, 5'd0, 1'b0); // back to back moves
		issueOp(opMtlo, 32'h2468ace0, 32'h0, 5'd0, 1'b0);
		issueOp(opMfhi, 32'h0, 32'h0, 5'd0, 1'b0);
		issueOp(opMflo, 32'h0, 32'h0, 5'd0, 1'b0);
		randomTraffic();
		repeat (3) idleCycle();
		if (expOp.size() != 0) begin
			otherErrors++;
			$display("%0d issued operations never produced a result", expOp.size());
		end
		$display("errors: %0d data, %0d assertion, %0d other",
			dataErrors, dut0.checker0.assertFails, otherErrors);
		if (dataErrors + otherErrors + dut0.checker0.assertFails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* src.f */
hw/exePkg.sv
hw/intAlu.sv
hw/mulDiv.sv
hw/hiLoResult.sv
hw/exeUnit.sv
test/clockGen.sv
test/exeUnit_checker.sv
test/exeUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module exeUnitTb -f src.f
output=$(./obj_dir/VexeUnitTb +verilator+error+limit+1000) || true
echo "$output"
echo "$output" | grep -q "Test completed successfully"
